// ==== common/arcade_input_pkg.sv ====
// Shared types and constants of the player input front end
// Keyboard word, key events, joystick word, control outputs, DIP banks
// PS/2 scan codes of the mapped keys and the download constants
`default_nettype none

package arcade_input_pkg;

    ////////////////////////////////////////
    // Keyboard side
    ////////////////////////////////////////

    // PS/2 key word, extended flag is not decoded
    typedef struct packed {
        logic       toggle;
        logic       pressed;
        logic       extended;
        logic [7:0] code;
    } ps2_key_t;

    localparam int NUM_BUTTONS = 13;

    // Bit positions of the keyboard button state vector
    typedef enum logic [3:0] {
        BTN_UP     = 4'd0,
        BTN_DOWN   = 4'd1,
        BTN_LEFT   = 4'd2,
        BTN_RIGHT  = 4'd3,
        BTN_A      = 4'd4,
        BTN_B      = 4'd5,
        BTN_X      = 4'd6,
        BTN_Y      = 4'd7,
        BTN_COIN1  = 4'd8,
        BTN_COIN2  = 4'd9,
        BTN_START1 = 4'd10,
        BTN_START2 = 4'd11,
        BTN_PAUSE  = 4'd12
    } btn_id_e;

    typedef struct packed {
        btn_id_e button;
        logic    pressed;
    } key_event_t;

    // Set 2 scan codes
    localparam logic [7:0] SC_START1 = 8'h16;
    localparam logic [7:0] SC_START2 = 8'h1E;
    localparam logic [7:0] SC_COIN1  = 8'h2E;
    localparam logic [7:0] SC_COIN2  = 8'h36;
    localparam logic [7:0] SC_PAUSE  = 8'h4D;
    localparam logic [7:0] SC_UP     = 8'h75;
    localparam logic [7:0] SC_DOWN   = 8'h72;
    localparam logic [7:0] SC_LEFT   = 8'h6B;
    localparam logic [7:0] SC_RIGHT  = 8'h74;
    // Ctrl, alt, space and shift
    localparam logic [7:0] SC_A      = 8'h14;
    localparam logic [7:0] SC_B      = 8'h11;
    localparam logic [7:0] SC_X      = 8'h29;
    localparam logic [7:0] SC_Y      = 8'h12;

    ////////////////////////////////////////
    // Joysticks and controls
    ////////////////////////////////////////

    // USB joystick word, active high
    typedef struct packed {
        logic [3:0] unused;
        logic       pause;
        logic       start2;
        logic       coin1;
        logic       start1;
        logic       y;
        logic       x;
        logic       b;
        logic       a;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_word_t;

    // Active low, joystick is {up, down, left, right}, buttons are {a, b, x, y}
    typedef struct packed {
        logic [3:0] joystick;
        logic [3:0] buttons;
    } player_ctrl_t;

    // Coin and start are active low, pause is active high
    typedef struct packed {
        player_ctrl_t p1;
        player_ctrl_t p2;
        logic [1:0]   coin;
        logic [1:0]   start;
        logic         pause;
    } arcade_ctrl_t;

    // Two active-low DIP banks
    typedef struct packed {
        logic [7:0] bank1;
        logic [7:0] bank0;
    } dip_bank_t;

    localparam logic [7:0] DIP_INDEX = 8'd254;
    localparam int IOCTL_ADDR_W = 25;

endpackage

`default_nettype wire

// ==== compile.f ====
common/arcade_input_pkg.sv
key_path/key_decoder.sv
key_path/key_event_fifo.sv
key_path/control_mapper.sv
hdl/dip_switch_bank.sv
hdl/arcade_input_top.sv
verification/tb_arcade_input.sv

// ==== hdl/arcade_input_top.sv ====
// Top of the player input front end
// Keyboard decoder, event FIFO and control mapper, plus the DIP bank
`timescale 1ns/100ps
`default_nettype none

module arcade_input_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                                   CLK_32M,
    input  wire logic                                   rst,
    input  wire arcade_input_pkg::ps2_key_t             ps2_key,
    input  wire arcade_input_pkg::joy_word_t            joystick_0,
    input  wire arcade_input_pkg::joy_word_t            joystick_1,
    input  wire logic                                   ioctl_wr,
    input  wire logic [7:0]                             ioctl_index,
    input  wire logic [arcade_input_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
    input  wire logic [7:0]                             ioctl_dout,
    output arcade_input_pkg::arcade_ctrl_t              controls,
    output arcade_input_pkg::dip_bank_t                 dip_sw
);

    // Decoder to FIFO, no handshake
    logic                         push;
    arcade_input_pkg::key_event_t push_event;
    logic                         fifo_full;

    // FIFO to mapper, four-phase link
    logic                         req;
    logic                         ack;
    arcade_input_pkg::key_event_t ev;

    key_decoder u_key_decoder (
        .CLK_32M    (CLK_32M),
        .rst        (rst),
        .ps2_key    (ps2_key),
        .full       (fifo_full),
        .push       (push),
        .push_event (push_event)
    );

    key_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_key_event_fifo (
        .CLK_32M    (CLK_32M),
        .rst        (rst),
        .push       (push),
        .push_event (push_event),
        .ack        (ack),
        .full       (fifo_full),
        .req        (req),
        .ev         (ev)
    );

    control_mapper u_control_mapper (
        .CLK_32M    (CLK_32M),
        .rst        (rst),
        .req        (req),
        .ev         (ev),
        .joystick_0 (joystick_0),
        .joystick_1 (joystick_1),
        .ack        (ack),
        .controls   (controls)
    );

    dip_switch_bank u_dip_switch_bank (
        .CLK_32M     (CLK_32M),
        .rst         (rst),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .dip_sw      (dip_sw)
    );

endmodule

`default_nettype wire

// ==== hdl/dip_switch_bank.sv ====
// DIP switch capture from the ROM download port
// Eight stored bytes, the first two presented as active-low banks
`timescale 1ns/100ps
`default_nettype none

module dip_switch_bank (
    input  wire logic                                   CLK_32M,
    input  wire logic                                   rst,
    input  wire logic                                   ioctl_wr,
    input  wire logic [7:0]                             ioctl_index,
    input  wire logic [arcade_input_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
    input  wire logic [7:0]                             ioctl_dout,
    output arcade_input_pkg::dip_bank_t                 dip_sw
);

    logic [7:0] dip_bytes [8];
    logic       dip_wr;

    // Only the first eight addresses of the DIP index carry switch data
    assign dip_wr = ioctl_wr
                 && (ioctl_index == arcade_input_pkg::DIP_INDEX)
                 && (ioctl_addr[arcade_input_pkg::IOCTL_ADDR_W-1:3] == '0);

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                dip_bytes[i] <= 8'h00;
            end
        end else if (dip_wr) begin
            dip_bytes[ioctl_addr[2:0]] <= ioctl_dout;
        end
    end

    // Bytes 2 to 7 are kept but not used by this board
    assign dip_sw.bank1 = ~dip_bytes[1];
    assign dip_sw.bank0 = ~dip_bytes[0];

endmodule

`default_nettype wire

// ==== key_path/control_mapper.sv ====
// Control mapper
// Keyboard button state, receiver side of the event link,
// joystick merge and the registered active-low controls
`timescale 1ns/100ps
`default_nettype none

module control_mapper (
    input  wire logic                         CLK_32M,
    input  wire logic                         rst,
    input  wire logic                         req,
    input  wire arcade_input_pkg::key_event_t ev,
    input  wire arcade_input_pkg::joy_word_t  joystick_0,
    input  wire arcade_input_pkg::joy_word_t  joystick_1,
    output logic                              ack,
    output arcade_input_pkg::arcade_ctrl_t    controls
);

    localparam arcade_input_pkg::arcade_ctrl_t CTRL_RELEASED = '{
        p1:    8'hFF,
        p2:    8'hFF,
        coin:  2'b11,
        start: 2'b11,
        pause: 1'b0
    };

    logic [arcade_input_pkg::NUM_BUTTONS-1:0] kbd_state;
    logic                                     accept;
    arcade_input_pkg::arcade_ctrl_t           ctrl_next;

    // One player's lines, keyboard is shared by both players
    function automatic arcade_input_pkg::player_ctrl_t merge_player(
        input logic [arcade_input_pkg::NUM_BUTTONS-1:0] kb,
        input arcade_input_pkg::joy_word_t              joy
    );
        arcade_input_pkg::player_ctrl_t p;
        p.joystick = ~{kb[arcade_input_pkg::BTN_UP]    | joy.up,
                       kb[arcade_input_pkg::BTN_DOWN]  | joy.down,
                       kb[arcade_input_pkg::BTN_LEFT]  | joy.left,
                       kb[arcade_input_pkg::BTN_RIGHT] | joy.right};
        p.buttons  = ~{kb[arcade_input_pkg::BTN_A] | joy.a,
                       kb[arcade_input_pkg::BTN_B] | joy.b,
                       kb[arcade_input_pkg::BTN_X] | joy.x,
                       kb[arcade_input_pkg::BTN_Y] | joy.y};
        return p;
    endfunction

    // First cycle of a request
    assign accept = req && !ack;

    ////////////////////////////////////////
    // Receiver side and button state
    ////////////////////////////////////////

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            ack       <= 1'b0;
            kbd_state <= '0;
        end else begin
            ack <= req;
            if (accept) begin
                kbd_state[ev.button] <= ev.pressed;
            end
        end
    end

    // Merge with the joysticks
    always_comb begin
        ctrl_next.p1       = merge_player(kbd_state, joystick_0);
        ctrl_next.p2       = merge_player(kbd_state, joystick_1);
        ctrl_next.start[0] = ~(kbd_state[arcade_input_pkg::BTN_START1]
                               | joystick_0.start1 | joystick_1.start1);
        ctrl_next.start[1] = ~(kbd_state[arcade_input_pkg::BTN_START2]
                               | joystick_0.start2 | joystick_1.start2);
        ctrl_next.coin[0]  = ~(kbd_state[arcade_input_pkg::BTN_COIN1]
                               | joystick_0.coin1 | joystick_1.coin1);
        // No joystick bit for the second coin
        ctrl_next.coin[1]  = ~kbd_state[arcade_input_pkg::BTN_COIN2];
        ctrl_next.pause    = kbd_state[arcade_input_pkg::BTN_PAUSE]
                             | joystick_0.pause | joystick_1.pause;
    end

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            controls <= CTRL_RELEASED;
        end else begin
            controls <= ctrl_next;
        end
    end

    // Sender holds req until it sees ack
    a_ack_after_req: assert property (
        @(posedge CLK_32M) disable iff (rst)
        $rose(ack) |-> req
    );

endmodule

`default_nettype wire

// ==== key_path/key_decoder.sv ====
// PS/2 key event decoder
// Toggle change detection and scan code to button translation
`timescale 1ns/100ps
`default_nettype none

module key_decoder (
    input  wire logic                         CLK_32M,
    input  wire logic                         rst,
    input  wire arcade_input_pkg::ps2_key_t   ps2_key,
    input  wire logic                         full,
    output logic                              push,
    output arcade_input_pkg::key_event_t      push_event
);

    logic                      last_toggle;
    logic                      key_change;
    logic                      code_known;
    arcade_input_pkg::btn_id_e code_button;

    assign key_change = (ps2_key.toggle != last_toggle);

    // Scan code lookup
    always_comb begin
        code_known  = 1'b1;
        code_button = arcade_input_pkg::BTN_UP;
        case (ps2_key.code)
            arcade_input_pkg::SC_START1: code_button = arcade_input_pkg::BTN_START1;
            arcade_input_pkg::SC_START2: code_button = arcade_input_pkg::BTN_START2;
            arcade_input_pkg::SC_COIN1:  code_button = arcade_input_pkg::BTN_COIN1;
            arcade_input_pkg::SC_COIN2:  code_button = arcade_input_pkg::BTN_COIN2;
            arcade_input_pkg::SC_PAUSE:  code_button = arcade_input_pkg::BTN_PAUSE;
            arcade_input_pkg::SC_UP:     code_button = arcade_input_pkg::BTN_UP;
            arcade_input_pkg::SC_DOWN:   code_button = arcade_input_pkg::BTN_DOWN;
            arcade_input_pkg::SC_LEFT:   code_button = arcade_input_pkg::BTN_LEFT;
            arcade_input_pkg::SC_RIGHT:  code_button = arcade_input_pkg::BTN_RIGHT;
            arcade_input_pkg::SC_A:      code_button = arcade_input_pkg::BTN_A;
            arcade_input_pkg::SC_B:      code_button = arcade_input_pkg::BTN_B;
            arcade_input_pkg::SC_X:      code_button = arcade_input_pkg::BTN_X;
            arcade_input_pkg::SC_Y:      code_button = arcade_input_pkg::BTN_Y;
            default:                     code_known  = 1'b0;
        endcase
    end

    always_ff @(posedge CLK_32M) begin
        // Toggle followed through reset as well so a stale word gives no event
        last_toggle <= ps2_key.toggle;
        if (rst) begin
            push <= 1'b0;
        end else begin
            // A change right after a push is dropped so the full flag
            // seen here is never one push behind
            push <= key_change && code_known && !full && !push;
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (key_change) begin
            push_event.button  <= code_button;
            push_event.pressed <= ps2_key.pressed;
        end
    end

    // FIFO always has room when the registered push arrives
    a_push_not_full: assert property (
        @(posedge CLK_32M) disable iff (rst)
        push |-> !full
    );

endmodule

`default_nettype wire

// ==== key_path/key_event_fifo.sv ====
// Key event FIFO
// Circular buffer with a four-phase req/ack sender on its head entry
`timescale 1ns/100ps
`default_nettype none

module key_event_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                         CLK_32M,
    input  wire logic                         rst,
    input  wire logic                         push,
    input  wire arcade_input_pkg::key_event_t push_event,
    input  wire logic                         ack,
    output logic                              full,
    output logic                              req,
    output arcade_input_pkg::key_event_t      ev
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    arcade_input_pkg::key_event_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == DEPTH_CNT);
    assign do_push = push && !full;
    // Ack only rises while req is up, so this is the rising ack
    assign do_pop  = req && ack;

    // Head entry, held while req is up since rd_ptr moves only on pop
    assign ev = mem[rd_ptr];

    always_ff @(posedge CLK_32M) begin
        if (do_push) begin
            mem[wr_ptr] <= push_event;
        end
    end

    ////////////////////////////////////////
    // Pointers, count and sender side
    ////////////////////////////////////////

    always_ff @(posedge CLK_32M) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            req    <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // New request only once the previous ack has gone low
            if (do_pop) begin
                req <= 1'b0;
            end else if (!req && !ack && (count != '0)) begin
                req <= 1'b1;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge CLK_32M) disable iff (rst)
        count <= DEPTH_CNT
    );

    a_ev_stable: assert property (
        @(posedge CLK_32M) disable iff (rst)
        (req && $past(req)) |-> $stable(ev)
    );

endmodule

`default_nettype wire

// ==== verification/tb_arcade_input.sv ====
// Testbench for the player input front end
// Random key events, joystick words and DIP writes from a fixed seed
// Reference model of the button state, control merge and DIP bytes
`timescale 1ns/100ps
`default_nettype none

module tb_arcade_input;

    localparam int N_KEY = 300;
    localparam int N_JOY = 200;
    localparam int N_DIP = 200;
    localparam int N_MIX = 200;
    localparam int TOTAL_STEPS = N_KEY + N_JOY + N_DIP + N_MIX + 1;

    logic                                   CLK_32M;
    logic                                   rst;
    arcade_input_pkg::ps2_key_t             ps2_key;
    arcade_input_pkg::joy_word_t            joystick_0;
    arcade_input_pkg::joy_word_t            joystick_1;
    logic                                   ioctl_wr;
    logic [7:0]                             ioctl_index;
    logic [arcade_input_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
    logic [7:0]                             ioctl_dout;
    arcade_input_pkg::arcade_ctrl_t         controls;
    arcade_input_pkg::dip_bank_t            dip_sw;

    // Reference model state
    integer      seed;
    logic [12:0] model_kbd;
    logic        model_toggle;
    logic [7:0]  model_dip [8];

    arcade_input_top #(
        .FIFO_DEPTH (4)
    ) dut (
        .CLK_32M     (CLK_32M),
        .rst         (rst),
        .ps2_key     (ps2_key),
        .joystick_0  (joystick_0),
        .joystick_1  (joystick_1),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .controls    (controls),
        .dip_sw      (dip_sw)
    );

    always begin
        #10 CLK_32M = ~CLK_32M;
    end

    ////////////////////////////////////////
    // Model
    ////////////////////////////////////////

    // Order is up, down, left, right, a, b, x, y, coin1, coin2, start1, start2, pause
    function automatic int button_index(input logic [7:0] code);
        case (code)
            8'h75:   return 0;
            8'h72:   return 1;
            8'h6B:   return 2;
            8'h74:   return 3;
            8'h14:   return 4;
            8'h11:   return 5;
            8'h29:   return 6;
            8'h12:   return 7;
            8'h2E:   return 8;
            8'h36:   return 9;
            8'h16:   return 10;
            8'h1E:   return 11;
            8'h4D:   return 12;
            default: return -1;
        endcase
    endfunction

    // Joystick bits 0..3 are right, left, down, up and 4..7 are a, b, x, y
    function automatic arcade_input_pkg::player_ctrl_t expect_player(
        input logic [12:0] kb,
        input logic [15:0] j
    );
        arcade_input_pkg::player_ctrl_t p;
        p.joystick = ~{kb[0] | j[3], kb[1] | j[2], kb[2] | j[1], kb[3] | j[0]};
        p.buttons  = ~{kb[4] | j[4], kb[5] | j[5], kb[6] | j[6], kb[7] | j[7]};
        return p;
    endfunction

    function automatic arcade_input_pkg::arcade_ctrl_t expect_controls(
        input logic [12:0] kb,
        input logic [15:0] j0,
        input logic [15:0] j1
    );
        arcade_input_pkg::arcade_ctrl_t c;
        c.p1       = expect_player(kb, j0);
        c.p2       = expect_player(kb, j1);
        c.start[0] = ~(kb[10] | j0[8] | j1[8]);
        c.start[1] = ~(kb[11] | j0[10] | j1[10]);
        c.coin[0]  = ~(kb[8] | j0[9] | j1[9]);
        c.coin[1]  = ~kb[9];
        c.pause    = kb[12] | j0[11] | j1[11];
        return c;
    endfunction

    ////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////

    task automatic check_controls(input arcade_input_pkg::arcade_ctrl_t expected);
        if (controls !== expected) begin
            $display("Mismatch at %0t: controls got %h expected %h",
                     $time, controls, expected);
            $display("TB FAILED");
            $fatal(1, "controls differ from the model");
        end
    endtask

    task automatic check_dip(input arcade_input_pkg::dip_bank_t expected);
        if (dip_sw !== expected) begin
            $display("Mismatch at %0t: dip_sw got %h expected %h", $time, dip_sw, expected);
            $display("TB FAILED");
            $fatal(1, "dip_sw differs from the model");
        end
    endtask

    task automatic step(input int cycles);
        repeat (cycles) @(posedge CLK_32M);
        #2;
    endtask

    // Half listed codes, toggle flipped three times out of four
    task automatic apply_key();
        arcade_input_pkg::ps2_key_t k;
        logic [7:0] listed [13];
        int idx;
        listed = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11, 8'h29, 8'h12,
                   8'h2E, 8'h36, 8'h16, 8'h1E, 8'h4D};
        k = ps2_key;
        if ($random(seed) & 1) begin
            k.code = listed[($random(seed) & 32'h7fff_ffff) % 13];
        end else begin
            k.code = $random(seed);
        end
        k.pressed  = $random(seed);
        k.extended = $random(seed);
        if (($random(seed) & 3) != 0) begin
            k.toggle = ~k.toggle;
        end
        if (k.toggle != model_toggle) begin
            idx = button_index(k.code);
            if (idx >= 0) begin
                model_kbd[idx] = k.pressed;
            end
        end
        model_toggle = k.toggle;
        ps2_key = k;
    endtask

    task automatic apply_dip_write();
        arcade_input_pkg::dip_bank_t exp_dip;
        ioctl_wr   = 1'b1;
        ioctl_dout = $random(seed);
        if ($random(seed) & 1) begin
            ioctl_index = 8'd254;
            ioctl_addr  = $random(seed) & 7;
        end else if ($random(seed) & 1) begin
            ioctl_index = $random(seed);
            ioctl_addr  = $random(seed) & 7;
        end else begin
            ioctl_index = 8'd254;
            ioctl_addr  = $random(seed);
            if (ioctl_addr[24:3] == '0) begin
                ioctl_addr[3] = 1'b1;
            end
        end
        if (ioctl_index == 8'd254 && ioctl_addr[24:3] == '0) begin
            model_dip[ioctl_addr[2:0]] = ioctl_dout;
        end
        step(1);
        ioctl_wr = 1'b0;
        exp_dip.bank1 = ~model_dip[1];
        exp_dip.bank0 = ~model_dip[0];
        check_dip(exp_dip);
    endtask

    // Watchdog sized from the number of steps
    initial begin
        #(TOTAL_STEPS * 20 * 20 + 10000);
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed        = 32'ha8ff;
        CLK_32M     = 1'b0;
        rst         = 1'b1;
        ps2_key     = '0;
        joystick_0  = '0;
        joystick_1  = '0;
        ioctl_wr    = 1'b0;
        ioctl_index = 8'd0;
        ioctl_addr  = '0;
        ioctl_dout  = 8'd0;
        model_kbd    = '0;
        model_toggle = 1'b0;
        for (int i = 0; i < 8; i++) begin
            model_dip[i] = 8'h00;
        end

        step(8);
        rst = 1'b0;
        step(1);
        check_controls(expect_controls(model_kbd, joystick_0, joystick_1));
        check_dip(16'hFFFF);

        // Key events spaced well apart so the FIFO never fills
        for (int n = 0; n < N_KEY; n++) begin
            apply_key();
            step(8);
            check_controls(expect_controls(model_kbd, joystick_0, joystick_1));
            step(2);
        end

        for (int n = 0; n < N_JOY; n++) begin
            joystick_0 = $random(seed);
            joystick_1 = $random(seed);
            step(1);
            check_controls(expect_controls(model_kbd, joystick_0, joystick_1));
        end

        for (int n = 0; n < N_DIP; n++) begin
            apply_dip_write();
        end

        // Joysticks and keys together
        for (int n = 0; n < N_MIX; n++) begin
            joystick_0 = $random(seed);
            joystick_1 = $random(seed);
            apply_key();
            step(8);
            check_controls(expect_controls(model_kbd, joystick_0, joystick_1));
            step(2);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
